//--- logic/intra_pkg.sv
// Shared constants and types of the 4x4 intra-prediction unit.
// Every module takes what it needs by a wildcard import.

package intra_pkg;

  // ------------------------------
  // sizes
  // ------------------------------
  localparam int PIX_W     = 8;
  localparam int BLK       = 4;
  localparam int NREF      = 5;
  localparam int REF_IDX_W = $clog2(NREF);
  localparam int ROW_IDX_W = $clog2(BLK);

  typedef logic [PIX_W-1:0] pix_t;

  // stands in for a side that is not available
  localparam pix_t MID_GREY = pix_t'(1 << (PIX_W - 1));

  // ------------------------------
  // commands and data
  // ------------------------------
  typedef enum logic [1:0] {
    MODE_PLANAR = 2'd0,
    MODE_DC     = 2'd1,
    MODE_HOR    = 2'd2,
    MODE_VER    = 2'd3
  } pred_mode_e;

  typedef struct packed {
    pred_mode_e mode;
    logic       avail_top;
    logic       avail_left;
  } pred_cmd_t;

  // index 4 is top-right on top, bottom-left on left
  typedef struct packed {
    pix_t [NREF-1:0] top;
    pix_t [NREF-1:0] left;
  } ref_set_t;

  // x=0 sits at the msb end
  typedef pix_t [0:BLK-1] pred_row_t;

  // row 0 sits at the msb end
  typedef pred_row_t [0:BLK-1] pred_blk_t;

endpackage

//--- logic/intra_ref_load.sv
// Neighbour pixel store for the 4x4 intra unit.
// Reconstruction writes one pixel at a time; a capture takes a substituted copy.

`timescale 1ns/10ps

module intra_ref_load import intra_pkg::*; (
  input  logic                 clk,
  input  logic                 reset_i,
  // reconstruction write port
  input  logic                 rec_val_i,
  input  logic                 rec_side_i,
  input  logic [REF_IDX_W-1:0] rec_idx_i,
  input  pix_t                 rec_dat_i,
  // capture
  input  logic                 cap_en_i,
  input  pred_cmd_t            cmd_i,
  output ref_set_t             ref_o
);

  pix_t [NREF-1:0] top_q;
  pix_t [NREF-1:0] left_q;

  // ------------------------------
  // neighbour register file
  // ------------------------------
  always_ff @(posedge clk) begin
    if (reset_i) begin
      top_q  <= '0;
      left_q <= '0;
    end else if (rec_val_i && (rec_idx_i < NREF)) begin
      // side 0 is the top row, side 1 the left column
      if (rec_side_i) begin
        left_q[rec_idx_i] <= rec_dat_i;
      end else begin
        top_q[rec_idx_i] <= rec_dat_i;
      end
    end
  end

  // ------------------------------
  // capture at start
  // ------------------------------
  // reads the values from before a write on the same edge
  always_ff @(posedge clk) begin
    if (cap_en_i) begin
      if (cmd_i.avail_top) begin
        ref_o.top <= top_q;
      end else begin
        ref_o.top <= {NREF{MID_GREY}};
      end
      if (cmd_i.avail_left) begin
        ref_o.left <= left_q;
      end else begin
        ref_o.left <= {NREF{MID_GREY}};
      end
    end
  end

  // ------------------------------
  // checks
  // ------------------------------
  a_rec_idx_range: assert property (
    @(posedge clk) disable iff (reset_i)
    rec_val_i |-> (rec_idx_i < NREF)
  ) else $error("reconstruction write index %0d out of range", rec_idx_i);

endmodule

//--- logic/intra_ctrl.sv
// Block sequencer of the 4x4 intra unit.
// Accepts a start while idle and stays busy until the last row leaves.

`timescale 1ns/10ps

module intra_ctrl import intra_pkg::*; (
  input  logic       clk,
  input  logic       reset_i,
  input  logic       start_i,
  input  pred_cmd_t  cmd_i,
  input  logic       row_last_i,
  output logic       cap_en_o,
  output logic       pred_go_o,
  output pred_mode_e mode_o
);

  logic       busy_q;
  pred_mode_e mode_q;

  // start while busy is dropped
  assign cap_en_o = start_i && !busy_q;
  assign mode_o   = mode_q;

  // ------------------------------
  // idle / busy
  // ------------------------------
  always_ff @(posedge clk) begin
    if (reset_i) begin
      busy_q    <= 1'b0;
      pred_go_o <= 1'b0;
    end else begin
      pred_go_o <= cap_en_o;
      if (cap_en_o) begin
        busy_q <= 1'b1;
      end else if (row_last_i) begin
        busy_q <= 1'b0;
      end
    end
  end

  // mode held for the core while the block is in flight
  always_ff @(posedge clk) begin
    if (cap_en_o) begin
      mode_q <= cmd_i.mode;
    end
  end

  // ------------------------------
  // checks
  // ------------------------------
  // the output side only finishes blocks that were started here
  a_no_last_when_idle: assert property (
    @(posedge clk) disable iff (reset_i)
    row_last_i |-> busy_q
  ) else $error("last row seen while controller idle");

endmodule

//--- logic/intra_pred_core.sv
// Prediction datapath of the 4x4 intra unit.
// Two register stages: references and DC sum first, then the sixteen pixels.
// A new block may enter every cycle.

`timescale 1ns/10ps

module intra_pred_core import intra_pkg::*; (
  input  logic       clk,
  input  logic       reset_i,
  input  logic       pred_go_i,
  input  pred_mode_e mode_i,
  input  ref_set_t   ref_i,
  output logic       blk_val_o,
  output pred_blk_t  blk_o
);

  // eight weighted terms plus rounding fit in PIX_W+3 bits, one spare
  localparam int SUM_W = PIX_W + 4;
  localparam int SHIFT = $clog2(2 * BLK);

  logic             val1_q;
  pred_mode_e       mode1_q;
  ref_set_t         ref1_q;
  logic [SUM_W-1:0] dc_sum;
  logic [SUM_W-1:0] dc_sum_q;
  logic [SUM_W-1:0] dc_rnd;
  pred_blk_t        blk_nxt;

  // ------------------------------
  // stage 1
  // ------------------------------
  always_comb begin
    dc_sum = '0;
    for (int i = 0; i < BLK; i++) begin
      dc_sum = dc_sum + SUM_W'(ref_i.top[i]) + SUM_W'(ref_i.left[i]);
    end
  end

  always_ff @(posedge clk) begin
    if (reset_i) begin
      val1_q <= 1'b0;
    end else begin
      val1_q <= pred_go_i;
    end
  end

  always_ff @(posedge clk) begin
    if (pred_go_i) begin
      mode1_q  <= mode_i;
      ref1_q   <= ref_i;
      dc_sum_q <= dc_sum;
    end
  end

  // ------------------------------
  // stage 2
  // ------------------------------
  assign dc_rnd = dc_sum_q + SUM_W'(BLK);

  always_comb begin
    logic [SUM_W-1:0] planar_v;
    planar_v = '0;
    for (int y = 0; y < BLK; y++) begin
      for (int x = 0; x < BLK; x++) begin
        // horizontal and vertical blends of the two sides
        planar_v = SUM_W'(BLK - 1 - x) * SUM_W'(ref1_q.left[y])
                 + SUM_W'(x + 1) * SUM_W'(ref1_q.top[BLK])
                 + SUM_W'(BLK - 1 - y) * SUM_W'(ref1_q.top[x])
                 + SUM_W'(y + 1) * SUM_W'(ref1_q.left[BLK])
                 + SUM_W'(BLK);
        case (mode1_q)
          MODE_DC:  blk_nxt[y][x] = dc_rnd[SHIFT +: PIX_W];
          MODE_HOR: blk_nxt[y][x] = ref1_q.left[y];
          MODE_VER: blk_nxt[y][x] = ref1_q.top[x];
          default:  blk_nxt[y][x] = planar_v[SHIFT +: PIX_W];
        endcase
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset_i) begin
      blk_val_o <= 1'b0;
    end else begin
      blk_val_o <= val1_q;
    end
  end

  always_ff @(posedge clk) begin
    if (val1_q) begin
      blk_o <= blk_nxt;
    end
  end

endmodule

//--- logic/intra_row_out.sv
// Output side of the 4x4 intra unit.
// Holds a finished block and sends it one row per cycle, done with row 3.

`timescale 1ns/10ps

module intra_row_out import intra_pkg::*; (
  input  logic                 clk,
  input  logic                 reset_i,
  input  logic                 blk_val_i,
  input  pred_blk_t            blk_i,
  output logic                 pre_val_o,
  output logic [ROW_IDX_W-1:0] pre_row_idx_o,
  output pred_row_t            pre_row_o,
  output logic                 done_o,
  output logic                 row_last_o
);

  localparam logic [ROW_IDX_W-1:0] LAST_ROW = ROW_IDX_W'(BLK - 1);

  logic                 val_q;
  logic [ROW_IDX_W-1:0] row_q;
  pred_blk_t            blk_q;

  // ------------------------------
  // row counter
  // ------------------------------
  always_ff @(posedge clk) begin
    if (reset_i) begin
      val_q <= 1'b0;
      row_q <= '0;
    end else if (blk_val_i) begin
      val_q <= 1'b1;
      row_q <= '0;
    end else if (val_q) begin
      row_q <= row_q + 1'b1;
      if (row_q == LAST_ROW) begin
        val_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (blk_val_i) begin
      blk_q <= blk_i;
    end
  end

  assign pre_val_o     = val_q;
  assign pre_row_idx_o = row_q;
  assign pre_row_o     = blk_q[row_q];
  assign row_last_o    = val_q && (row_q == LAST_ROW);
  assign done_o        = row_last_o;

  // no room for a second block while rows are going out
  a_no_overrun: assert property (
    @(posedge clk) disable iff (reset_i)
    blk_val_i |-> !val_q
  ) else $error("block arrived while row %0d still being sent", row_q);

endmodule

//--- logic/intra_top.sv
// Top of the 4x4 intra-prediction unit.
// Reference store, sequencer, prediction core and row output.

`timescale 1ns/10ps

module intra_top import intra_pkg::*; (
  input  logic                 clk,
  input  logic                 reset_i,
  // control
  input  logic                 start_i,
  input  pred_cmd_t            cmd_i,
  // reconstruction
  input  logic                 rec_val_i,
  input  logic                 rec_side_i,
  input  logic [REF_IDX_W-1:0] rec_idx_i,
  input  pix_t                 rec_dat_i,
  // prediction out
  output logic                 pre_val_o,
  output logic [ROW_IDX_W-1:0] pre_row_idx_o,
  output pred_row_t            pre_row_o,
  output logic                 done_o
);

  logic       cap_en;
  logic       pred_go;
  pred_mode_e mode;
  ref_set_t   ref_set;
  logic       blk_val;
  pred_blk_t  blk;
  logic       row_last;

  intra_ref_load u_intra_ref_load (
    .clk        (clk),
    .reset_i    (reset_i),
    .rec_val_i  (rec_val_i),
    .rec_side_i (rec_side_i),
    .rec_idx_i  (rec_idx_i),
    .rec_dat_i  (rec_dat_i),
    .cap_en_i   (cap_en),
    .cmd_i      (cmd_i),
    .ref_o      (ref_set)
  );

  intra_ctrl u_intra_ctrl (
    .clk        (clk),
    .reset_i    (reset_i),
    .start_i    (start_i),
    .cmd_i      (cmd_i),
    .row_last_i (row_last),
    .cap_en_o   (cap_en),
    .pred_go_o  (pred_go),
    .mode_o     (mode)
  );

  intra_pred_core u_intra_pred_core (
    .clk        (clk),
    .reset_i    (reset_i),
    .pred_go_i  (pred_go),
    .mode_i     (mode),
    .ref_i      (ref_set),
    .blk_val_o  (blk_val),
    .blk_o      (blk)
  );

  intra_row_out u_intra_row_out (
    .clk           (clk),
    .reset_i       (reset_i),
    .blk_val_i     (blk_val),
    .blk_i         (blk),
    .pre_val_o     (pre_val_o),
    .pre_row_idx_o (pre_row_idx_o),
    .pre_row_o     (pre_row_o),
    .done_o        (done_o),
    .row_last_o    (row_last)
  );

endmodule

//--- dv/intra_model.svh
// Random source and reference model for the intra-prediction testbench.
// Included inside the testbench module; mirrors the neighbour store and predicts blocks.

`ifndef INTRA_MODEL_SVH
`define INTRA_MODEL_SVH

// ------------------------------
// random numbers
// ------------------------------
logic [31:0] lfsr_state = 32'h13f6_ee4e;

// taps 32, 22, 2, 1
function automatic logic lfsr_step();
  logic fb;
  fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
  lfsr_state = {lfsr_state[30:0], fb};
  return fb;
endfunction

// one step per bit taken
function automatic logic [31:0] rand_bits(input int n);
  logic [31:0] v;
  v = '0;
  for (int i = 0; i < n; i++) begin
    v = {v[30:0], lfsr_step()};
  end
  return v;
endfunction

// ------------------------------
// reference model
// ------------------------------
int mir_top[5];
int mir_left[5];
int exp_pix[4][4];

function automatic void mirror_write(input logic side, input int idx, input int dat);
  if (side) begin
    mir_left[idx] = dat;
  end else begin
    mir_top[idx] = dat;
  end
endfunction

// fills exp_pix from the mirror as it stands at the start edge
function automatic void predict_block(input pred_cmd_t cmd);
  int t[5];
  int l[5];
  int mid;
  int dc;
  mid = 1 << (PIX_W - 1);
  dc = 4;
  for (int i = 0; i < 5; i++) begin
    t[i] = cmd.avail_top ? mir_top[i] : mid;
    l[i] = cmd.avail_left ? mir_left[i] : mid;
  end
  for (int i = 0; i < 4; i++) begin
    dc = dc + t[i] + l[i];
  end
  for (int y = 0; y < 4; y++) begin
    for (int x = 0; x < 4; x++) begin
      case (cmd.mode)
        MODE_DC:  exp_pix[y][x] = dc >> 3;
        MODE_HOR: exp_pix[y][x] = l[y];
        MODE_VER: exp_pix[y][x] = t[x];
        default: begin
          exp_pix[y][x] = ((3 - x) * l[y] + (x + 1) * t[4]
                         + (3 - y) * t[x] + (y + 1) * l[4] + 4) >> 3;
        end
      endcase
    end
  end
endfunction

// pixel 0 in the top byte
function automatic logic [31:0] exp_row(input int y);
  logic [31:0] r;
  r = '0;
  for (int x = 0; x < 4; x++) begin
    r = {r[23:0], 8'(exp_pix[y][x])};
  end
  return r;
endfunction

`endif

//--- dv/tb_intra_top.sv
// Testbench for the 4x4 intra-prediction unit.
// Random references and modes, checked row by row against a model; summary at the end.

`timescale 1ns/10ps

module tb_intra_top import intra_pkg::*; ();

  localparam int CLK_PERIOD = 100;
  localparam int N_RAND     = 24;
  // reset, random, substitution, timing, busy, start-edge write
  localparam int N_BLOCKS   = 1 + N_RAND + 4 + 1 + 1 + 2;
  localparam int WD_CYCLES  = N_BLOCKS * 20 + 100;

  logic                 clk;
  logic                 reset_i;
  logic                 start_i;
  pred_cmd_t            cmd_i;
  logic                 rec_val_i;
  logic                 rec_side_i;
  logic [REF_IDX_W-1:0] rec_idx_i;
  pix_t                 rec_dat_i;
  logic                 pre_val_o;
  logic [ROW_IDX_W-1:0] pre_row_idx_o;
  pred_row_t            pre_row_o;
  logic                 done_o;

  string test_name;
  int    test_errs;
  int    test_checks;
  int    err_total;
  int    check_total;
  int    tests_run;
  int    tests_failed;

  `include "intra_model.svh"

  intra_top intra_top_i (
    .clk           (clk),
    .reset_i       (reset_i),
    .start_i       (start_i),
    .cmd_i         (cmd_i),
    .rec_val_i     (rec_val_i),
    .rec_side_i    (rec_side_i),
    .rec_idx_i     (rec_idx_i),
    .rec_dat_i     (rec_dat_i),
    .pre_val_o     (pre_val_o),
    .pre_row_idx_o (pre_row_idx_o),
    .pre_row_o     (pre_row_o),
    .done_o        (done_o)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin
    repeat (WD_CYCLES) @(posedge clk);
    $display("Timeout: the run did not finish within %0d cycles", WD_CYCLES);
    $display("Errors found");
    $finish;
  end

  // ------------------------------
  // helpers
  // ------------------------------
  function automatic pred_cmd_t make_cmd(input pred_mode_e m, input logic t, input logic l);
    pred_cmd_t c;
    c.mode       = m;
    c.avail_top  = t;
    c.avail_left = l;
    return c;
  endfunction

  task automatic begin_test(input string name);
    test_name   = name;
    test_errs   = 0;
    test_checks = 0;
  endtask

  task automatic end_test();
    tests_run++;
    if (test_errs != 0) begin
      tests_failed++;
    end
    err_total   += test_errs;
    check_total += test_checks;
    $display("test %-14s %s: %0d checks, %0d errors", test_name,
             (test_errs == 0) ? "ok" : "FAILED", test_checks, test_errs);
  endtask

  task automatic check_val(input string what, input int cyc,
                           input logic [31:0] exp, input logic [31:0] act);
    test_checks++;
    if (exp !== act) begin
      test_errs++;
      $display("Mismatch %s %s cycle %0d: expected %h actual %h",
               test_name, what, cyc, exp, act);
    end
  endtask

  // starts and ends on a falling edge
  task automatic write_ref(input logic side, input int idx, input int dat);
    rec_val_i  = 1'b1;
    rec_side_i = side;
    rec_idx_i  = REF_IDX_W'(idx);
    rec_dat_i  = pix_t'(dat);
    mirror_write(side, idx, dat);
    @(negedge clk);
    rec_val_i = 1'b0;
  endtask

  task automatic start_block(input pred_cmd_t cmd);
    start_i = 1'b1;
    cmd_i   = cmd;
    predict_block(cmd);
  endtask

  // start edge is cycle 0; rows expected in cycles 3 to 6
  task automatic collect_block(input bit poke_busy);
    pred_cmd_t other;
    other = make_cmd((cmd_i.mode == MODE_DC) ? MODE_VER : MODE_DC,
                     !cmd_i.avail_top, cmd_i.avail_left);
    for (int k = 0; k < 8; k++) begin
      @(negedge clk);
      check_val("pre_val_o", k, 32'(k >= 3 && k <= 6), 32'(pre_val_o));
      check_val("done_o", k, 32'(k == 6), 32'(done_o));
      if (k >= 3 && k <= 6) begin
        check_val("pre_row_idx_o", k, 32'(k - 3), 32'(pre_row_idx_o));
        check_val("pre_row_o", k, exp_row(k - 3), pre_row_o);
      end
      rec_val_i = 1'b0;
      // busy through the edge that ends row 3
      if (poke_busy && k < 7) begin
        start_i = 1'b1;
        cmd_i   = other;
      end else begin
        start_i = 1'b0;
      end
    end
  endtask

  task automatic idle_watch(input int n);
    for (int k = 0; k < n; k++) begin
      @(negedge clk);
      check_val("pre_val_o idle", k, 32'd0, 32'(pre_val_o));
      check_val("done_o idle", k, 32'd0, 32'(done_o));
    end
  endtask

  // ------------------------------
  // tests
  // ------------------------------
  initial begin
    int nwr;
    reset_i    = 1'b1;
    start_i    = 1'b0;
    cmd_i      = '0;
    rec_val_i  = 1'b0;
    rec_side_i = 1'b0;
    rec_idx_i  = '0;
    rec_dat_i  = '0;
    err_total    = 0;
    check_total  = 0;
    tests_run    = 0;
    tests_failed = 0;
    repeat (10) @(negedge clk);
    reset_i = 1'b0;

    // nothing written yet, so DC of zeros
    begin_test("reset_state");
    idle_watch(20);
    start_block(make_cmd(MODE_DC, 1'b1, 1'b1));
    collect_block(1'b0);
    end_test();

    begin_test("random_modes");
    for (int i = 0; i < 10; i++) begin
      write_ref(i >= 5, i % 5, int'(rand_bits(8)));
    end
    for (int b = 0; b < N_RAND; b++) begin
      nwr = int'(rand_bits(3));
      for (int w = 0; w < nwr; w++) begin
        write_ref(1'(rand_bits(1)), int'(rand_bits(3) % 5), int'(rand_bits(8)));
      end
      start_block(make_cmd(pred_mode_e'(2'(rand_bits(2))), 1'b1, 1'b1));
      collect_block(1'b0);
    end
    end_test();

    begin_test("substitution");
    start_block(make_cmd(MODE_VER, 1'b0, 1'b1));
    collect_block(1'b0);
    start_block(make_cmd(MODE_HOR, 1'b1, 1'b0));
    collect_block(1'b0);
    start_block(make_cmd(MODE_DC, 1'b0, 1'b0));
    collect_block(1'b0);
    start_block(make_cmd(MODE_PLANAR, 1'b0, 1'b1));
    collect_block(1'b0);
    end_test();

    begin_test("output_timing");
    write_ref(1'b0, 4, int'(rand_bits(8)));
    start_block(make_cmd(MODE_PLANAR, 1'b1, 1'b1));
    collect_block(1'b0);
    end_test();

    begin_test("start_busy");
    start_block(make_cmd(MODE_HOR, 1'b1, 1'b1));
    collect_block(1'b1);
    idle_watch(8);
    end_test();

    // write lands on the start edge of the first block only
    begin_test("start_edge_wr");
    start_block(make_cmd(MODE_VER, 1'b1, 1'b1));
    rec_val_i  = 1'b1;
    rec_side_i = 1'b0;
    rec_idx_i  = REF_IDX_W'(2);
    rec_dat_i  = pix_t'(mir_top[2] ^ 255);
    mirror_write(1'b0, 2, mir_top[2] ^ 255);
    collect_block(1'b0);
    start_block(make_cmd(MODE_VER, 1'b1, 1'b1));
    collect_block(1'b0);
    end_test();

    $display("summary: %0d tests, %0d failed, %0d checks, %0d errors",
             tests_run, tests_failed, check_total, err_total);
    if (err_total == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

//--- intra_top.f
+incdir+dv
logic/intra_pkg.sv
logic/intra_ref_load.sv
logic/intra_ctrl.sv
logic/intra_pred_core.sv
logic/intra_row_out.sv
logic/intra_top.sv
dv/tb_intra_top.sv

//--- run_sim.sh
#!/bin/sh
# build with Verilator, run, then look for the fail message in the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir
verilator --binary --timing --assert -f intra_top.f --top-module tb_intra_top \
  -o sim_intra > build.log 2>&1 && ./obj_dir/sim_intra > sim.log 2>&1 \
  || { cat build.log sim.log 2>/dev/null; echo "build or simulation failed"; exit 1; }
cat sim.log
grep -q "Errors found" sim.log && exit 1 || exit 0
